//--- Makefile
TOP := tb_cpu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f filelist.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module cpu_top -f filelist.f

clean:
	rm -rf obj_dir

//--- filelist.f
rtl/cpu_pkg.sv
rtl/cpu_links.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
testbench/cpu_checker.sv
testbench/tb_cpu.sv

//--- rtl/cpu_links.sv
`timescale 1ns/100ps

// decode -> execute
interface dec_ex_if;
  import cpu_pkg::*;

  logic                      valid;
  logic [ALU_OP_WIDTH-1:0]   alu_op;
  logic                      use_imm;
  logic                      mem_read;
  logic                      mem_write;
  logic                      reg_write;
  logic                      is_beq;
  logic                      is_bne;
  logic                      is_halt;
  logic [REG_ADDR_WIDTH-1:0] rs;
  logic [REG_ADDR_WIDTH-1:0] rt;
  logic [REG_ADDR_WIDTH-1:0] dest;
  logic [DATA_WIDTH-1:0]     op_a;
  logic [DATA_WIDTH-1:0]     op_b;
  logic [IMM_WIDTH-1:0]      imm;
  logic [SHAMT_WIDTH-1:0]    shamt;

  modport source (output valid, alu_op, use_imm, mem_read, mem_write, reg_write, is_beq,
                  is_bne, is_halt, rs, rt, dest, op_a, op_b, imm, shamt);
  modport sink (input valid, alu_op, use_imm, mem_read, mem_write, reg_write, is_beq,
                is_bne, is_halt, rs, rt, dest, op_a, op_b, imm, shamt);
endinterface

// execute -> memory, plus forward tap back into execute
interface ex_mem_if;
  import cpu_pkg::*;

  logic                      valid;
  logic [DATA_WIDTH-1:0]     alu_result;
  logic [DATA_WIDTH-1:0]     store_data;
  logic [REG_ADDR_WIDTH-1:0] dest;
  logic                      reg_write;
  logic                      mem_read;
  logic                      mem_write;
  logic                      is_halt;

  modport source (output valid, alu_result, store_data, dest, reg_write, mem_read,
                  mem_write, is_halt);
  modport sink (input valid, alu_result, store_data, dest, reg_write, mem_read,
                mem_write, is_halt);
  modport fwd (input valid, alu_result, dest, reg_write, mem_read);
endinterface

// writeback, read by decode and execute
interface wb_if;
  import cpu_pkg::*;

  logic                      valid;
  logic                      reg_write;
  logic [REG_ADDR_WIDTH-1:0] dest;
  logic [DATA_WIDTH-1:0]     value;
  logic                      is_halt;

  modport source (output valid, reg_write, dest, value, is_halt);
  modport sink (input valid, reg_write, dest, value, is_halt);
endinterface

//--- rtl/cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int DATA_WIDTH     = 32;
  localparam int INST_WIDTH     = 32;
  localparam int ADDR_WIDTH     = 8;
  localparam int MEM_DEPTH      = 1 << ADDR_WIDTH;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int NUM_REGS       = 1 << REG_ADDR_WIDTH;
  localparam int IMM_WIDTH      = 16;
  localparam int SHAMT_WIDTH    = 5;
  localparam int OPCODE_WIDTH   = 6;
  localparam int FUNCT_WIDTH    = 6;
  localparam int ALU_OP_WIDTH   = 3;

  // opcodes, anything else runs as a nop
  localparam logic [OPCODE_WIDTH-1:0] OP_RTYPE = 6'd0;
  localparam logic [OPCODE_WIDTH-1:0] OP_ADDI  = 6'd8;
  localparam logic [OPCODE_WIDTH-1:0] OP_LW    = 6'd35;
  localparam logic [OPCODE_WIDTH-1:0] OP_SW    = 6'd43;
  localparam logic [OPCODE_WIDTH-1:0] OP_BEQ   = 6'd4;
  localparam logic [OPCODE_WIDTH-1:0] OP_BNE   = 6'd5;
  localparam logic [OPCODE_WIDTH-1:0] OP_HALT  = 6'd63;

  // r-type function codes
  localparam logic [FUNCT_WIDTH-1:0] FN_ADD = 6'd32;
  localparam logic [FUNCT_WIDTH-1:0] FN_SUB = 6'd34;
  localparam logic [FUNCT_WIDTH-1:0] FN_AND = 6'd36;
  localparam logic [FUNCT_WIDTH-1:0] FN_OR  = 6'd37;
  localparam logic [FUNCT_WIDTH-1:0] FN_SLT = 6'd42;
  localparam logic [FUNCT_WIDTH-1:0] FN_SLL = 6'd0;

  // alu operations; none yields zero
  localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD  = 3'd0;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB  = 3'd1;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_AND  = 3'd2;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OR   = 3'd3;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLT  = 3'd4;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL  = 3'd5;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_NONE = 3'd7;

  //////////////////////////////////////////////////
  // instruction word, two views
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [OPCODE_WIDTH-1:0]   opcode;
    logic [REG_ADDR_WIDTH-1:0] rs;
    logic [REG_ADDR_WIDTH-1:0] rt;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [SHAMT_WIDTH-1:0]    shamt;
    logic [FUNCT_WIDTH-1:0]    funct;
  } r_fields_t;

  typedef struct packed {
    logic [OPCODE_WIDTH-1:0]   opcode;
    logic [REG_ADDR_WIDTH-1:0] rs;
    logic [REG_ADDR_WIDTH-1:0] rt;
    logic [IMM_WIDTH-1:0]      imm;
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_t;

endpackage

//--- rtl/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             run,
  input  logic                             imem_we,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     imem_addr,
  input  logic [cpu_pkg::INST_WIDTH-1:0]     imem_wdata,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] dbg_reg_addr,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     dbg_reg_data,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     dbg_mem_addr,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     dbg_mem_data,
  output logic                             halted
);
  import cpu_pkg::*;

  instr_t                fd_instr;
  logic                  fd_valid;
  logic                  stall;
  logic                  hold;
  logic                  redirect;
  logic [ADDR_WIDTH-1:0] target;

  // stage links
  dec_ex_if dx_link ();
  ex_mem_if xm_link ();
  wb_if     wb_link ();

  fetch_stage u_fetch (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .stall       (stall),
    .hold        (hold),
    .redirect    (redirect),
    .target      (target),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .instr       (fd_instr),
    .instr_valid (fd_valid)
  );

  decode_stage u_decode (
    .clk          (clk),
    .rst          (rst),
    .instr        (fd_instr),
    .instr_valid  (fd_valid),
    .stall        (stall),
    .hold         (hold),
    .redirect     (redirect),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data),
    .dx           (dx_link.source),
    .wb           (wb_link.sink)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst      (rst),
    .dx       (dx_link.sink),
    .xm       (xm_link.source),
    .xm_fwd   (xm_link.fwd),
    .wb       (wb_link.sink),
    .redirect (redirect),
    .target   (target)
  );

  memory_stage u_memory (
    .clk          (clk),
    .rst          (rst),
    .xm           (xm_link.sink),
    .wb           (wb_link.source),
    .dbg_mem_addr (dbg_mem_addr),
    .dbg_mem_data (dbg_mem_data),
    .halted       (halted)
  );

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
  input  logic                             clk,
  input  logic                             rst,
  input  cpu_pkg::instr_t                  instr,
  input  logic                             instr_valid,
  output logic                             stall,
  output logic                             hold,
  input  logic                             redirect,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] dbg_reg_addr,
  output logic [cpu_pkg::DATA_WIDTH-1:0]     dbg_reg_data,
  dec_ex_if.source                         dx,
  wb_if.sink                               wb
);
  import cpu_pkg::*;

  logic [DATA_WIDTH-1:0]     regs [NUM_REGS];
  logic [REG_ADDR_WIDTH-1:0] rs;
  logic [REG_ADDR_WIDTH-1:0] rt;
  logic [REG_ADDR_WIDTH-1:0] dest;
  logic [DATA_WIDTH-1:0]     rs_data;
  logic [DATA_WIDTH-1:0]     rt_data;
  logic [ALU_OP_WIDTH-1:0]   alu_op;
  logic                      use_imm;
  logic                      mem_read;
  logic                      mem_write;
  logic                      reg_write;
  logic                      is_beq;
  logic                      is_bne;
  logic                      is_halt;
  logic                      uses_rs;
  logic                      uses_rt;
  logic                      wb_hit;
  logic                      issue;

  assign rs = instr.i.rs;
  assign rt = instr.i.rt;

  //////////////////////////////////////////////////
  // control decode
  //////////////////////////////////////////////////

  always_comb begin
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    is_beq    = 1'b0;
    is_bne    = 1'b0;
    is_halt   = 1'b0;
    uses_rs   = 1'b0;
    uses_rt   = 1'b0;
    dest      = instr.i.rt;
    case (instr.r.opcode)
      OP_RTYPE: begin
        reg_write = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
        dest      = instr.r.rd;
        case (instr.r.funct)
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLL:  alu_op = ALU_SLL;
          default: alu_op = ALU_NONE;
        endcase
      end
      OP_ADDI: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        uses_rs   = 1'b1;
      end
      OP_LW: begin
        use_imm   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
        uses_rs   = 1'b1;
      end
      OP_SW: begin
        use_imm   = 1'b1;
        mem_write = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
      end
      OP_BEQ: begin
        is_beq  = 1'b1;
        uses_rs = 1'b1;
        uses_rt = 1'b1;
      end
      OP_BNE: begin
        is_bne  = 1'b1;
        uses_rs = 1'b1;
        uses_rt = 1'b1;
      end
      OP_HALT: is_halt = 1'b1;
      default: ;
    endcase
  end

  // load in execute feeding this instruction
  assign stall = instr_valid && dx.valid && dx.mem_read && (dx.dest != '0) &&
                 ((uses_rs && (rs == dx.dest)) || (uses_rt && (rt == dx.dest)));
  assign issue = instr_valid && !stall && !hold && !redirect;

  //////////////////////////////////////////////////
  // register file with write-through on read
  //////////////////////////////////////////////////

  assign wb_hit = wb.valid && wb.reg_write && (wb.dest != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (wb_hit) begin
      regs[wb.dest] <= wb.value;
    end
  end

  assign rs_data = (rs == '0) ? '0 : (wb_hit && (wb.dest == rs)) ? wb.value : regs[rs];
  assign rt_data = (rt == '0) ? '0 : (wb_hit && (wb.dest == rt)) ? wb.value : regs[rt];
  assign dbg_reg_data = regs[dbg_reg_addr];

  // d/x valid and halt latch
  always_ff @(posedge clk) begin
    if (rst) begin
      dx.valid <= 1'b0;
      hold     <= 1'b0;
    end else begin
      dx.valid <= issue;
      if (issue && is_halt) begin
        hold <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    dx.alu_op    <= alu_op;
    dx.use_imm   <= use_imm;
    dx.mem_read  <= mem_read;
    dx.mem_write <= mem_write;
    dx.reg_write <= reg_write;
    dx.is_beq    <= is_beq;
    dx.is_bne    <= is_bne;
    dx.is_halt   <= is_halt;
    dx.rs        <= rs;
    dx.rt        <= rt;
    dx.dest      <= dest;
    dx.op_a      <= rs_data;
    dx.op_b      <= rt_data;
    dx.imm       <= instr.i.imm;
    dx.shamt     <= instr.r.shamt;
  end

  // stall and flush bubbles reach writeback without a register write
  a_bubble_no_write: assert property (@(posedge clk) disable iff (rst)
    (stall || redirect) |-> ##3 !wb.valid);

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
  input  logic                         clk,
  input  logic                         rst,
  dec_ex_if.sink                       dx,
  ex_mem_if.source                     xm,
  ex_mem_if.fwd                        xm_fwd,
  wb_if.sink                           wb,
  output logic                         redirect,
  output logic [cpu_pkg::ADDR_WIDTH-1:0] target
);
  import cpu_pkg::*;

  logic                  xm_ok;
  logic                  wb_ok;
  logic [DATA_WIDTH-1:0] fwd_a;
  logic [DATA_WIDTH-1:0] fwd_b;
  logic [DATA_WIDTH-1:0] alu_b;
  logic [DATA_WIDTH-1:0] alu_result;
  logic                  slt_bit;
  logic                  equal;

  //////////////////////////////////////////////////
  // forwarding, x/m first then writeback
  //////////////////////////////////////////////////

  // a load in x/m only carries its address here
  assign xm_ok = xm_fwd.valid && xm_fwd.reg_write && !xm_fwd.mem_read && (xm_fwd.dest != '0);
  assign wb_ok = wb.valid && wb.reg_write && (wb.dest != '0);

  always_comb begin
    if (xm_ok && (xm_fwd.dest == dx.rs)) begin
      fwd_a = xm_fwd.alu_result;
    end else if (wb_ok && (wb.dest == dx.rs)) begin
      fwd_a = wb.value;
    end else begin
      fwd_a = dx.op_a;
    end
  end

  always_comb begin
    if (xm_ok && (xm_fwd.dest == dx.rt)) begin
      fwd_b = xm_fwd.alu_result;
    end else if (wb_ok && (wb.dest == dx.rt)) begin
      fwd_b = wb.value;
    end else begin
      fwd_b = dx.op_b;
    end
  end

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////

  assign alu_b   = dx.use_imm ? {{(DATA_WIDTH - IMM_WIDTH){1'b0}}, dx.imm} : fwd_b;
  assign slt_bit = $signed(fwd_a) < $signed(alu_b);

  always_comb begin
    case (dx.alu_op)
      ALU_ADD: alu_result = fwd_a + alu_b;
      ALU_SUB: alu_result = fwd_a - alu_b;
      ALU_AND: alu_result = fwd_a & alu_b;
      ALU_OR:  alu_result = fwd_a | alu_b;
      ALU_SLT: alu_result = {{(DATA_WIDTH - 1){1'b0}}, slt_bit};
      ALU_SLL: alu_result = fwd_b << dx.shamt;
      default: alu_result = '0;
    endcase
  end

  // branch target is an absolute word address
  assign equal    = (fwd_a == fwd_b);
  assign redirect = dx.valid && ((dx.is_beq && equal) || (dx.is_bne && !equal));
  assign target   = dx.imm[ADDR_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      xm.valid <= 1'b0;
    end else begin
      xm.valid <= dx.valid;
    end
  end

  always_ff @(posedge clk) begin
    xm.alu_result <= alu_result;
    xm.store_data <= fwd_b;
    xm.dest       <= dx.dest;
    xm.reg_write  <= dx.reg_write;
    xm.mem_read   <= dx.mem_read;
    xm.mem_write  <= dx.mem_write;
    xm.is_halt    <= dx.is_halt;
  end

  // a taken branch comes from a branch and leaves a bubble behind it
  a_redirect_branch: assert property (@(posedge clk) disable iff (rst)
    redirect |-> (dx.is_beq || dx.is_bne) ##1 !dx.valid);

endmodule

//--- rtl/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  input  logic                         stall,
  input  logic                         hold,
  input  logic                         redirect,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] target,
  input  logic                         imem_we,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] imem_addr,
  input  logic [cpu_pkg::INST_WIDTH-1:0] imem_wdata,
  output cpu_pkg::instr_t              instr,
  output logic                         instr_valid
);
  import cpu_pkg::*;

  logic [ADDR_WIDTH-1:0] pc;
  logic [INST_WIDTH-1:0] imem [MEM_DEPTH];

  // load port written while fetch is parked
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  // redirect beats stall and hold for pc and f/d valid
  always_ff @(posedge clk) begin
    if (rst || !run) begin
      pc          <= '0;
      instr_valid <= 1'b0;
    end else if (redirect) begin
      pc          <= target;
      instr_valid <= 1'b0;
    end else if (!(stall || hold)) begin
      pc          <= pc + 1'b1;
      instr_valid <= 1'b1;
    end
  end

  // f/d instruction word
  always_ff @(posedge clk) begin
    if (!(stall || hold)) begin
      instr <= imem[pc];
    end
  end

  // program is loaded only while fetch sits at address 0
  a_no_load_while_running: assert property (@(posedge clk) disable iff (rst)
    run |-> !imem_we);

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/100ps

module memory_stage (
  input  logic                         clk,
  input  logic                         rst,
  ex_mem_if.sink                       xm,
  wb_if.source                         wb,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0] dbg_mem_addr,
  output logic [cpu_pkg::DATA_WIDTH-1:0] dbg_mem_data,
  output logic                         halted
);
  import cpu_pkg::*;

  logic [DATA_WIDTH-1:0] dmem [MEM_DEPTH];
  logic [ADDR_WIDTH-1:0] dmem_addr;
  logic [DATA_WIDTH-1:0] load_data;
  logic                  halted_q;

  // word address from the low alu bits
  assign dmem_addr    = xm.alu_result[ADDR_WIDTH-1:0];
  assign load_data    = dmem[dmem_addr];
  assign dbg_mem_data = dmem[dbg_mem_addr];

  always_ff @(posedge clk) begin
    if (xm.valid && xm.mem_write) begin
      dmem[dmem_addr] <= xm.store_data;
    end
  end

  //////////////////////////////////////////////////
  // m/w register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= xm.valid;
    end
  end

  always_ff @(posedge clk) begin
    wb.reg_write <= xm.reg_write;
    wb.dest      <= xm.dest;
    wb.value     <= xm.mem_read ? load_data : xm.alu_result;
    wb.is_halt   <= xm.is_halt;
  end

  // sticky once the halt reaches writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      halted_q <= 1'b0;
    end else if (wb.valid && wb.is_halt) begin
      halted_q <= 1'b1;
    end
  end

  assign halted = halted_q || (wb.valid && wb.is_halt);

  // nothing behind the halt reaches memory
  a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
    halted |-> !(xm.valid && xm.mem_write));

endmodule

//--- testbench/cpu_checker.sv
`timescale 1ns/100ps

module cpu_checker #(
  parameter int HALT_LIMIT = 400
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               run,
  input  logic                               imem_we,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     imem_addr,
  input  logic [cpu_pkg::INST_WIDTH-1:0]     imem_wdata,
  input  logic                               halted,
  input  logic                               reg_check,
  input  logic [cpu_pkg::REG_ADDR_WIDTH-1:0] dbg_reg_addr,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     dbg_reg_data,
  input  logic                               mem_check,
  input  logic [cpu_pkg::ADDR_WIDTH-1:0]     dbg_mem_addr,
  input  logic [cpu_pkg::DATA_WIDTH-1:0]     dbg_mem_data,
  output int                                 check_count,
  output int                                 error_count
);
  import cpu_pkg::*;

  localparam int STEP_LIMIT = 1000;

  logic [INST_WIDTH-1:0] prog [MEM_DEPTH];
  logic [DATA_WIDTH-1:0] model_regs [NUM_REGS];
  logic [DATA_WIDTH-1:0] model_mem [MEM_DEPTH];
  // data memory keeps its words across runs, so the model does too
  logic                  mem_known [MEM_DEPTH] = '{default: 1'b0};
  logic                  halted_seen;
  int                    wait_cycles;
  int                    checks = 0;
  int                    errors = 0;

  assign check_count = checks;
  assign error_count = errors;

  //////////////////////////////////////////////////
  // reference interpreter
  //////////////////////////////////////////////////

  function automatic void run_model();
    logic [31:0] w;
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sh;
    logic [15:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ea;
    logic [31:0] v;
    logic [7:0]  pc;
    int          steps;
    logic        done;
    for (int k = 0; k < NUM_REGS; k++) begin
      model_regs[k] = '0;
    end
    pc = '0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < STEP_LIMIT) begin
      w   = prog[pc];
      op  = w[31:26];
      rs  = w[25:21];
      rt  = w[20:16];
      rd  = w[15:11];
      sh  = w[10:6];
      fn  = w[5:0];
      imm = w[15:0];
      a   = model_regs[rs];
      b   = model_regs[rt];
      // offsets and addi immediates are zero-extended
      ea  = a + {16'd0, imm};
      pc  = pc + 8'd1;
      steps++;
      case (op)
        OP_RTYPE: begin
          case (fn)
            FN_ADD:  v = a + b;
            FN_SUB:  v = a - b;
            FN_AND:  v = a & b;
            FN_OR:   v = a | b;
            FN_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLL:  v = b << sh;
            default: v = '0;
          endcase
          if (rd != '0) model_regs[rd] = v;
        end
        OP_ADDI: if (rt != '0) model_regs[rt] = ea;
        OP_LW:   if (rt != '0) model_regs[rt] = model_mem[ea[7:0]];
        OP_SW: begin
          model_mem[ea[7:0]] = b;
          mem_known[ea[7:0]] = 1'b1;
        end
        // absolute word targets
        OP_BEQ:  if (a == b) pc = imm[7:0];
        OP_BNE:  if (a != b) pc = imm[7:0];
        OP_HALT: done = 1'b1;
        default: ;
      endcase
    end
    if (!done) begin
      errors++;
      $display("ERROR: reference model reached no halt within %0d steps", STEP_LIMIT);
    end
  endfunction

  //////////////////////////////////////////////////
  // program snoop, halt tracking, sweep compare
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (imem_we) prog[imem_addr] = imem_wdata;
    if (rst) begin
      halted_seen = 1'b0;
      wait_cycles = 0;
    end else begin
      if (run && !halted) begin
        wait_cycles++;
        if (wait_cycles == HALT_LIMIT) begin
          errors++;
          $display("ERROR: halted never rose within %0d cycles at %0t", HALT_LIMIT, $time);
        end
      end
      if (halted && !halted_seen) begin
        run_model();
        halted_seen = 1'b1;
      end else if (halted_seen && !halted) begin
        errors++;
        $display("ERROR: halted fell before reset at %0t", $time);
      end
    end
    if (reg_check) begin
      checks++;
      if (dbg_reg_data !== model_regs[dbg_reg_addr]) begin
        errors++;
        $display("FAILED t=%0t dbg_reg_data (r%0d): expected %h, actual %h",
                 $time, dbg_reg_addr, model_regs[dbg_reg_addr], dbg_reg_data);
      end
    end
    if (mem_check && mem_known[dbg_mem_addr]) begin
      checks++;
      if (dbg_mem_data !== model_mem[dbg_mem_addr]) begin
        errors++;
        $display("FAILED t=%0t dbg_mem_data (word %0d): expected %h, actual %h",
                 $time, dbg_mem_addr, model_mem[dbg_mem_addr], dbg_mem_data);
      end
    end
  end

endmodule

//--- testbench/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int CLK_PERIOD         = 10;
  localparam int NUM_DIRECTED       = 4;
  localparam int NUM_RANDOM         = 20;
  localparam int NUM_PROGRAMS       = NUM_DIRECTED + NUM_RANDOM;
  localparam int CYCLES_PER_PROGRAM = 700;
  localparam int HALT_LIMIT         = 400;

  logic                      clk;
  logic                      rst;
  logic                      run;
  logic                      imem_we;
  logic [ADDR_WIDTH-1:0]     imem_addr;
  logic [INST_WIDTH-1:0]     imem_wdata;
  logic [REG_ADDR_WIDTH-1:0] dbg_reg_addr;
  logic [DATA_WIDTH-1:0]     dbg_reg_data;
  logic [ADDR_WIDTH-1:0]     dbg_mem_addr;
  logic [DATA_WIDTH-1:0]     dbg_mem_data;
  logic                      halted;
  logic                      reg_check;
  logic                      mem_check;
  int                        check_count;
  int                        error_count;
  logic [31:0]               lfsr_state;
  logic [INST_WIDTH-1:0]     prog [$];

  cpu_top u_cpu_top (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data),
    .dbg_mem_addr (dbg_mem_addr),
    .dbg_mem_data (dbg_mem_data),
    .halted       (halted)
  );

  cpu_checker #(.HALT_LIMIT(HALT_LIMIT)) u_checker (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .halted       (halted),
    .reg_check    (reg_check),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data),
    .mem_check    (mem_check),
    .dbg_mem_addr (dbg_mem_addr),
    .dbg_mem_data (dbg_mem_data),
    .check_count  (check_count),
    .error_count  (error_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // lfsr and instruction encoding
  //////////////////////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] rtype_word(input logic [5:0] fn, input int rs, input int rt,
                                             input int rd, input int sh);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic logic [31:0] itype_word(input logic [5:0] op, input int rs, input int rt,
                                             input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  //////////////////////////////////////////////////
  // programs
  //////////////////////////////////////////////////

  task automatic directed_program(input int which);
    prog.delete();
    case (which)
      // dependent chain, forwards from x/m and writeback
      0: begin
        prog.push_back(itype_word(OP_ADDI, 0, 1, 5));
        prog.push_back(itype_word(OP_ADDI, 1, 2, 7));
        prog.push_back(rtype_word(FN_ADD, 1, 2, 3, 0));
        prog.push_back(rtype_word(FN_SUB, 3, 1, 4, 0));
        prog.push_back(rtype_word(FN_AND, 4, 3, 5, 0));
        prog.push_back(rtype_word(FN_OR, 5, 2, 6, 0));
        prog.push_back(rtype_word(FN_SLT, 5, 6, 7, 0));
        prog.push_back(rtype_word(FN_SLL, 0, 7, 8, 3));
        prog.push_back(itype_word(OP_ADDI, 8, 9, 1));
        prog.push_back(rtype_word(FN_SUB, 0, 9, 10, 0));
        prog.push_back(rtype_word(FN_SLT, 10, 9, 11, 0));
      end
      // stores, loads and load-use into alu, store data and address
      1: begin
        prog.push_back(itype_word(OP_ADDI, 0, 1, 'h1234));
        prog.push_back(itype_word(OP_ADDI, 0, 2, 'hff));
        prog.push_back(itype_word(OP_SW, 0, 1, 0));
        prog.push_back(itype_word(OP_SW, 0, 2, 5));
        prog.push_back(itype_word(OP_ADDI, 0, 3, 9));
        prog.push_back(itype_word(OP_SW, 3, 3, 3));
        prog.push_back(itype_word(OP_LW, 0, 4, 0));
        prog.push_back(rtype_word(FN_ADD, 4, 4, 5, 0));
        prog.push_back(itype_word(OP_LW, 0, 6, 12));
        prog.push_back(itype_word(OP_SW, 0, 6, 20));
        prog.push_back(itype_word(OP_LW, 0, 7, 5));
        prog.push_back(rtype_word(FN_SUB, 7, 2, 8, 0));
        prog.push_back(itype_word(OP_LW, 0, 9, 20));
        prog.push_back(itype_word(OP_SW, 9, 9, 0));
        prog.push_back(itype_word(OP_LW, 0, 10, 9));
      end
      // branches, markers in r10..r13 sit in taken shadows
      2: begin
        prog.push_back(itype_word(OP_ADDI, 0, 1, 3));
        prog.push_back(itype_word(OP_ADDI, 0, 2, 3));
        prog.push_back(itype_word(OP_BEQ, 1, 2, 5));
        prog.push_back(itype_word(OP_ADDI, 0, 10, 111));
        prog.push_back(itype_word(OP_ADDI, 0, 11, 111));
        prog.push_back(itype_word(OP_BNE, 1, 2, 8));
        prog.push_back(itype_word(OP_ADDI, 0, 3, 6));
        prog.push_back(itype_word(OP_ADDI, 0, 4, 7));
        prog.push_back(itype_word(OP_BNE, 1, 3, 11));
        prog.push_back(itype_word(OP_ADDI, 0, 12, 111));
        prog.push_back(itype_word(OP_ADDI, 0, 13, 111));
        prog.push_back(itype_word(OP_BEQ, 1, 3, 14));
        prog.push_back(itype_word(OP_ADDI, 0, 5, 12));
        prog.push_back(itype_word(OP_ADDI, 0, 6, 13));
      end
      // r0 writes, then work after the halt
      default: begin
        prog.push_back(itype_word(OP_ADDI, 0, 0, 99));
        prog.push_back(itype_word(OP_ADDI, 0, 1, 4));
        prog.push_back(rtype_word(FN_ADD, 1, 1, 0, 0));
        prog.push_back(rtype_word(FN_ADD, 0, 1, 2, 0));
        prog.push_back(itype_word(OP_SW, 0, 1, 1));
      end
    endcase
    prog.push_back(itype_word(OP_HALT, 0, 0, 0));
    if (which >= 3) begin
      prog.push_back(itype_word(OP_ADDI, 0, 3, 77));
      prog.push_back(itype_word(OP_SW, 0, 1, 0));
      prog.push_back(itype_word(OP_ADDI, 0, 4, 88));
    end
  endtask

  task automatic random_program();
    int         len;
    int         span;
    int         target;
    logic [2:0] kind;
    logic [5:0] fn;
    prog.delete();
    // seed registers, then fill words 0..15 so loads read known data
    for (int k = 0; k < 8; k++) begin
      prog.push_back(itype_word(OP_ADDI, 0, 1 + (k % 7), rand_bits(16)));
    end
    for (int k = 0; k < 16; k++) begin
      prog.push_back(itype_word(OP_SW, 0, rand_bits(3), k));
    end
    len = 29 + int'(rand_bits(5));
    while (prog.size() < len - 1) begin
      kind = 3'(rand_bits(3));
      case (kind)
        0, 1: begin
          case (3'(rand_bits(3)))
            0:       fn = FN_ADD;
            1:       fn = FN_SUB;
            2:       fn = FN_AND;
            3:       fn = FN_OR;
            4:       fn = FN_SLT;
            5:       fn = FN_SLL;
            6:       fn = 6'd1;
            default: fn = FN_ADD;
          endcase
          prog.push_back(rtype_word(fn, rand_bits(3), rand_bits(3), rand_bits(3), rand_bits(5)));
        end
        2: prog.push_back(itype_word(OP_ADDI, rand_bits(3), rand_bits(3), rand_bits(16)));
        3: prog.push_back(itype_word(OP_LW, 0, rand_bits(3), rand_bits(4)));
        4: prog.push_back(itype_word(OP_SW, rand_bits(3), rand_bits(3), rand_bits(8)));
        5, 6: begin
          // forward only, at most up to the halt
          span = len - 1 - prog.size();
          target = prog.size() + 1 + int'(rand_bits(6)) % span;
          prog.push_back(itype_word((kind == 3'd5) ? OP_BEQ : OP_BNE, rand_bits(3),
                                    rand_bits(3), target));
        end
        default: prog.push_back({6'd17, 26'(rand_bits(26))});
      endcase
    end
    prog.push_back(itype_word(OP_HALT, 0, 0, 0));
  endtask

  //////////////////////////////////////////////////
  // run sequence
  //////////////////////////////////////////////////

  task automatic reset_cpu();
    @(negedge clk);
    rst = 1'b1;
    run = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic load_program();
    foreach (prog[k]) begin
      @(negedge clk);
      imem_we    = 1'b1;
      imem_addr  = 8'(k);
      imem_wdata = prog[k];
    end
    @(negedge clk);
    imem_we = 1'b0;
    run     = 1'b1;
  endtask

  task automatic wait_halted();
    int n;
    n = 0;
    while (!halted && n < HALT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    // a few more cycles so late commits would show
    repeat (4) @(negedge clk);
  endtask

  task automatic sweep_regs();
    for (int k = 0; k < NUM_REGS; k++) begin
      @(negedge clk);
      dbg_reg_addr = 5'(k);
      reg_check    = 1'b1;
    end
    @(negedge clk);
    reg_check = 1'b0;
  endtask

  task automatic sweep_mem();
    for (int k = 0; k < MEM_DEPTH; k++) begin
      @(negedge clk);
      dbg_mem_addr = 8'(k);
      mem_check    = 1'b1;
    end
    @(negedge clk);
    mem_check = 1'b0;
  endtask

  task automatic run_program();
    reset_cpu();
    load_program();
    wait_halted();
    sweep_regs();
    sweep_mem();
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    run          = 1'b0;
    imem_we      = 1'b0;
    imem_addr    = '0;
    imem_wdata   = '0;
    dbg_reg_addr = '0;
    dbg_mem_addr = '0;
    reg_check    = 1'b0;
    mem_check    = 1'b0;
    lfsr_state   = 32'heef657a4;
    for (int p = 0; p < NUM_DIRECTED; p++) begin
      directed_program(p);
      run_program();
    end
    for (int p = 0; p < NUM_RANDOM; p++) begin
      random_program();
      run_program();
    end
    @(negedge clk);
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(NUM_PROGRAMS * CYCLES_PER_PROGRAM * CLK_PERIOD);
    $display("ERROR: run did not finish within %0d cycles", NUM_PROGRAMS * CYCLES_PER_PROGRAM);
    $display("checks: %0d  errors: %0d", check_count, error_count);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
